/* logic/axi_mem_pkg.sv */
// AXI4 memory slave shared types and constants
package axi_mem_pkg;

	// bus widths
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int id_w   = 4;
	localparam int len_w  = 8; // beats minus one
	localparam int strb_w = 4;

	localparam int queue_depth = 4;
	localparam int queue_ptr_w = $clog2(queue_depth);

	// memory map
	localparam logic [addr_w-1:0] ram_base   = 32'h8000_0000;
	localparam int                ram_bytes  = 4096;
	localparam int                ram_idx_w  = $clog2(ram_bytes);
	localparam logic [addr_w-1:0] timer_base = 32'ha000_0048; // low word, high word at +4

	localparam logic [1:0] resp_okay = 2'b00;

	// any other burst code behaves as fixed
	typedef enum logic [1:0] {
		burst_fixed = 2'd0,
		burst_incr  = 2'd1
	} burst_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [id_w-1:0]   id;
		logic [len_w-1:0]  len;
		logic [2:0]        size; // log2 bytes per beat
		burst_t            burst;
	} axi_req_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;
		logic              last;
	} w_beat_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [id_w-1:0]   id;
		logic [1:0]        resp;
		logic              last;
	} r_beat_t;

	typedef struct packed {
		logic [id_w-1:0] id;
		logic [1:0]      resp;
	} b_resp_t;

	// address of beat idx within a burst
	function automatic logic [addr_w-1:0] beat_addr(axi_req_t req, logic [len_w-1:0] idx);
		if (req.burst == burst_incr)
			return req.addr + (addr_w'(idx) << req.size);
		return req.addr; // fixed and reserved codes
	endfunction

endpackage

/* logic/req_queue.sv */
// circular request queue
`timescale 1ns/1ps

module req_queue
	import axi_mem_pkg::*;
#(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  payload_t push_data,
	input  logic     push,
	output logic     ready,
	output payload_t head,
	output logic     not_empty,
	input  logic     pop
);

	payload_t slots [queue_depth]; // payload storage
	logic [queue_ptr_w-1:0] head_ptr;
	logic [queue_ptr_w-1:0] tail_ptr;
	logic [queue_ptr_w:0] count; // occupancy from 0 up to depth

	function automatic logic [queue_ptr_w-1:0] wrap_inc(logic [queue_ptr_w-1:0] ptr);
		return (ptr == queue_ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign ready     = (count != (queue_ptr_w + 1)'(queue_depth)); // not full
	assign not_empty = (count != '0);
	assign head      = slots[head_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			if (push)
				tail_ptr <= wrap_inc(tail_ptr);
			if (pop)
				head_ptr <= wrap_inc(head_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			slots[tail_ptr] <= push_data;
	end

	// callers gate push and pop with the flags
	assert property (@(posedge clock) disable iff (reset) push |-> ready)
		else $error("req_queue push while full");
	assert property (@(posedge clock) disable iff (reset) pop |-> not_empty)
		else $error("req_queue pop while empty");

endmodule

/* logic/mem_map.sv */
// byte RAM and mtime window
`timescale 1ns/1ps

module mem_map
	import axi_mem_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  logic [addr_w-1:0] rd_addr,
	output logic [data_w-1:0] rd_data,
	input  logic [addr_w-1:0] wr_addr,
	input  logic [data_w-1:0] wr_data,
	input  logic [strb_w-1:0] wr_strb,
	input  logic              wr_en
);

	logic [7:0] ram [ram_bytes];
	logic [63:0] mtime;

	logic [addr_w-1:0] rd_word;
	logic [addr_w-1:0] rd_ram_off;
	logic [addr_w-1:0] rd_tmr_off;
	logic [addr_w-1:0] wr_word;
	logic [addr_w-1:0] wr_ram_off;
	logic rd_in_ram;
	logic rd_in_timer;
	logic wr_in_ram;

	// word align, then offset into each window
	assign rd_word    = {rd_addr[addr_w-1:2], 2'b00};
	assign rd_ram_off = rd_word - ram_base; // wraps high when below base
	assign rd_tmr_off = rd_word - timer_base;
	assign rd_in_ram   = (rd_ram_off < ram_bytes);
	assign rd_in_timer = (rd_tmr_off < addr_w'(8)); // two words
	assign wr_word    = {wr_addr[addr_w-1:2], 2'b00};
	assign wr_ram_off = wr_word - ram_base;
	assign wr_in_ram  = (wr_ram_off < ram_bytes);

	// free running machine timer
	always_ff @(posedge clock) begin
		if (reset)
			mtime <= '0;
		else
			mtime <= mtime + 1'b1;
	end

	always_comb begin
		rd_data = '0; // unmapped reads give zero
		if (rd_in_ram) begin
			for (int i = 0; i < strb_w; i++)
				rd_data[8*i +: 8] = ram[{rd_ram_off[ram_idx_w-1:2], 2'(i)}];
		end else if (rd_in_timer) begin
			rd_data = rd_tmr_off[2] ? mtime[63:32] : mtime[31:0];
		end
	end

	// strobed byte writes, RAM window only
	always_ff @(posedge clock) begin
		if (wr_en && wr_in_ram) begin
			for (int i = 0; i < strb_w; i++) begin
				if (wr_strb[i])
					ram[{wr_ram_off[ram_idx_w-1:2], 2'(i)}] <= wr_data[8*i +: 8];
			end
		end
	end

endmodule

/* logic/read_engine.sv */
// read burst engine, AR queue to R channel
`timescale 1ns/1ps

module read_engine
	import axi_mem_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  axi_req_t          req,
	input  logic              req_valid,
	output logic              req_pop,
	output logic [addr_w-1:0] rd_addr,
	input  logic [data_w-1:0] rd_data,
	output r_beat_t           r,
	output logic              r_valid,
	input  logic              r_ready
);

	axi_req_t cur; // request being served
	logic [len_w-1:0] cnt; // index of beat held in r
	logic [len_w-1:0] next_idx;
	logic step;
	logic done;
	logic load_new;

	assign next_idx = cnt + 1'b1;
	assign step     = r_valid && r_ready && !r.last; // beat taken, more to come
	assign done     = r_valid && r_ready && r.last;
	// new burst when idle or as the last beat leaves
	assign load_new = req_valid && (!r_valid || done);
	assign req_pop  = load_new;

	// first beat of the head request, else next beat of the current one
	assign rd_addr = load_new ? req.addr : beat_addr(cur, next_idx);

	always_ff @(posedge clock) begin
		if (reset) begin
			r_valid <= 1'b0;
			cnt     <= '0;
		end else if (load_new) begin
			r_valid <= 1'b1;
			cnt     <= '0;
		end else if (step) begin
			cnt <= next_idx;
		end else if (done) begin
			r_valid <= 1'b0;
		end
	end

	// beat payload, held under back-pressure
	always_ff @(posedge clock) begin
		if (load_new)
			cur <= req;
		if (load_new || step) begin
			r.data <= rd_data;
			r.id   <= load_new ? req.id : cur.id;
			r.resp <= resp_okay;
			r.last <= load_new ? (req.len == '0) : (next_idx == cur.len);
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("R beat changed while stalled");

endmodule

/* logic/write_engine.sv */
// write burst engine, AW queue and W channel to memory and B queue
`timescale 1ns/1ps

module write_engine
	import axi_mem_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  axi_req_t          req,
	input  logic              req_valid,
	output logic              req_pop,
	input  w_beat_t           w,
	input  logic              w_valid,
	output logic              w_ready,
	output logic [addr_w-1:0] wr_addr,
	output logic [data_w-1:0] wr_data,
	output logic [strb_w-1:0] wr_strb,
	output logic              wr_en,
	output logic              b_push,
	output b_resp_t           b_data,
	input  logic              b_ready
);

	axi_req_t cur;
	logic active; // holding a request
	logic [len_w-1:0] cnt; // beat index within burst
	logic last_beat;
	logic take;

	assign last_beat = (cnt == cur.len);
	// stall W when there is no room for the response
	assign w_ready = active && b_ready;
	assign wr_en   = w_valid && w_ready; // W handshake
	// next request taken as the last beat lands
	assign take    = req_valid && (!active || (wr_en && last_beat));
	assign req_pop = take;

	// same stepping rule as reads
	assign wr_addr = beat_addr(cur, cnt);
	assign wr_data = w.data;
	assign wr_strb = w.strb;

	assign b_push      = wr_en && last_beat;
	assign b_data.id   = cur.id;
	assign b_data.resp = resp_okay;

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			cnt    <= '0;
		end else if (take) begin
			active <= 1'b1;
			cnt    <= '0;
		end else if (wr_en) begin
			if (last_beat) begin
				active <= 1'b0; // burst finished
				cnt    <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take)
			cur <= req;
	end

	// master's wlast has to agree with the AW length
	assert property (@(posedge clock) disable iff (reset) wr_en |-> (w.last == last_beat))
		else $error("wlast does not match burst length");

endmodule

/* logic/axi_mem_top.sv */
// AXI4 memory slave top
`timescale 1ns/1ps

module axi_mem_top
	import axi_mem_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  axi_req_t ar,
	input  logic     ar_valid,
	output logic     ar_ready,
	output r_beat_t  r,
	output logic     r_valid,
	input  logic     r_ready,
	input  axi_req_t aw,
	input  logic     aw_valid,
	output logic     aw_ready,
	input  w_beat_t  w,
	input  logic     w_valid,
	output logic     w_ready,
	output b_resp_t  b,
	output logic     b_valid,
	input  logic     b_ready
);

	axi_req_t ar_head;
	axi_req_t aw_head;
	b_resp_t b_push_data;
	logic ar_head_valid;
	logic aw_head_valid;
	logic ar_pop;
	logic aw_pop;
	logic b_push;
	logic b_room; // B queue not full
	logic [addr_w-1:0] rd_addr;
	logic [data_w-1:0] rd_data;
	logic [addr_w-1:0] wr_addr;
	logic [data_w-1:0] wr_data;
	logic [strb_w-1:0] wr_strb;
	logic wr_en;

	req_queue #(.payload_t(axi_req_t)) ar_queue (
		.clock(clock), .reset(reset),
		.push_data(ar), .push(ar_valid && ar_ready), .ready(ar_ready),
		.head(ar_head), .not_empty(ar_head_valid), .pop(ar_pop)
	);

	req_queue #(.payload_t(axi_req_t)) aw_queue (
		.clock(clock), .reset(reset),
		.push_data(aw), .push(aw_valid && aw_ready), .ready(aw_ready),
		.head(aw_head), .not_empty(aw_head_valid), .pop(aw_pop)
	);

	// responses wait here so a slow bready never holds up W
	req_queue #(.payload_t(b_resp_t)) b_queue (
		.clock(clock), .reset(reset),
		.push_data(b_push_data), .push(b_push), .ready(b_room),
		.head(b), .not_empty(b_valid), .pop(b_valid && b_ready)
	);

	read_engine u_read (
		.clock(clock), .reset(reset),
		.req(ar_head), .req_valid(ar_head_valid), .req_pop(ar_pop),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.r(r), .r_valid(r_valid), .r_ready(r_ready)
	);

	write_engine u_write (
		.clock(clock), .reset(reset),
		.req(aw_head), .req_valid(aw_head_valid), .req_pop(aw_pop),
		.w(w), .w_valid(w_valid), .w_ready(w_ready),
		.wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb), .wr_en(wr_en),
		.b_push(b_push), .b_data(b_push_data), .b_ready(b_room)
	);

	mem_map u_mem (
		.clock(clock), .reset(reset),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb), .wr_en(wr_en)
	);

endmodule

/* testbench/axi_checker.sv */
// AXI memory slave checker and byte model
`timescale 1ns/1ps

module axi_checker
	import axi_mem_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  axi_req_t ar,
	input  logic     ar_valid,
	input  logic     ar_ready,
	input  r_beat_t  r,
	input  logic     r_valid,
	input  logic     r_ready,
	input  axi_req_t aw,
	input  logic     aw_valid,
	input  logic     aw_ready,
	input  w_beat_t  w,
	input  logic     w_valid,
	input  logic     w_ready,
	input  b_resp_t  b,
	input  logic     b_valid,
	input  logic     b_ready,
	output int       value_errors,
	output int       protocol_errors,
	output int       pending // requests not yet fully answered
);

	logic [7:0] model [ram_bytes];
	bit known [ram_bytes]; // byte written at least once
	axi_req_t ar_q[$];
	axi_req_t aw_q[$];
	logic [id_w-1:0] b_q[$]; // ids of finished write bursts
	int r_idx;
	int w_idx;
	logic [31:0] last_low; // previous mtime low word seen
	bit seen_low;
	r_beat_t r_prev;
	b_resp_t b_prev;
	bit r_stalled;
	bit b_stalled;

	// incr advances 2**size bytes per beat, fixed and reserved codes repeat the address
	function automatic logic [31:0] stepped(axi_req_t req, int beat);
		logic [31:0] stride;
		stride = (req.burst == burst_incr) ? (32'd1 << req.size) : 32'd0;
		return req.addr + stride * 32'(beat);
	endfunction

	always @(posedge clock) begin
		axi_req_t req;
		logic [31:0] a;
		logic [31:0] off;
		logic [31:0] exp;
		logic [31:0] mask;
		if (reset) begin
			r_idx = 0;
			w_idx = 0;
			seen_low = 0;
			r_stalled = 0;
			b_stalled = 0;
		end else begin
			// held beats must not move
			if (r_stalled && (!r_valid || r !== r_prev)) begin
				value_errors++;
				$display("Fail %0t: R beat dropped or changed while r_ready low", $time);
			end
			if (b_stalled && (!b_valid || b !== b_prev)) begin
				value_errors++;
				$display("Fail %0t: B response dropped or changed while b_ready low", $time);
			end
			r_stalled = r_valid && !r_ready;
			b_stalled = b_valid && !b_ready;
			r_prev = r;
			b_prev = b;
			if (ar_valid && ar_ready)
				ar_q.push_back(ar);
			if (aw_valid && aw_ready)
				aw_q.push_back(aw);
			if (b_valid && b_ready) begin
				if (b_q.size() == 0) begin
					protocol_errors++;
					$display("write response seen with no write burst finished");
				end else begin
					if (b.id !== b_q[0] || b.resp !== resp_okay) begin
						value_errors++;
						$display("Fail %0t: B id %h resp %h, expected id %h okay",
							$time, b.id, b.resp, b_q[0]);
					end
					void'(b_q.pop_front());
				end
			end
			if (w_valid && w_ready) begin
				if (aw_q.size() == 0) begin
					protocol_errors++;
					$display("write beat accepted with no write request outstanding");
				end else begin
					req = aw_q[0];
					a = stepped(req, w_idx);
					off = {a[31:2], 2'b00} - ram_base;
					if (off < ram_bytes) begin // outside RAM the write is lost
						for (int i = 0; i < strb_w; i++) begin
							if (w.strb[i]) begin
								model[{off[ram_idx_w-1:2], 2'(i)}] = w.data[8*i +: 8];
								known[{off[ram_idx_w-1:2], 2'(i)}] = 1;
							end
						end
					end
					if (w_idx == int'(req.len)) begin
						b_q.push_back(req.id);
						void'(aw_q.pop_front());
						w_idx = 0;
					end else begin
						w_idx++;
					end
				end
			end
			if (r_valid && r_ready) begin
				if (ar_q.size() == 0) begin
					protocol_errors++;
					$display("read beat arrived with no read request outstanding");
				end else begin
					req = ar_q[0];
					a = stepped(req, r_idx);
					a = {a[31:2], 2'b00};
					off = a - ram_base;
					exp = '0;
					mask = '1; // unmapped and timer high read as zero
					if (off < ram_bytes) begin
						mask = '0; // unwritten bytes are unknown
						for (int i = 0; i < strb_w; i++) begin
							if (known[{off[ram_idx_w-1:2], 2'(i)}]) begin
								mask[8*i +: 8] = 8'hff;
								exp[8*i +: 8] = model[{off[ram_idx_w-1:2], 2'(i)}];
							end
						end
					end else if (a == timer_base) begin
						mask = '0;
						if (seen_low && r.data <= last_low) begin
							value_errors++;
							$display("Fail %0t: mtime low %h not above previous %h",
								$time, r.data, last_low);
						end
						seen_low = 1;
						last_low = r.data;
					end
					if ((r.data & mask) !== exp || r.id !== req.id || r.resp !== resp_okay
						|| r.last !== (r_idx == int'(req.len))) begin
						value_errors++;
						$display("Fail %0t: R at %h got data %h id %h last %b, expected %h id %h",
							$time, a, r.data, r.id, r.last, exp, req.id);
					end
					if (r_idx == int'(req.len)) begin
						void'(ar_q.pop_front());
						r_idx = 0;
					end else begin
						r_idx++;
					end
				end
			end
		end
		pending = ar_q.size() + aw_q.size() + b_q.size();
	end

endmodule

/* testbench/tb_top.sv */
// AXI memory slave testbench top
`timescale 1ns/1ps

module tb_top
	import axi_mem_pkg::*;
();

	logic clock;
	logic reset;
	axi_req_t ar;
	logic ar_valid;
	logic ar_ready;
	r_beat_t r;
	logic r_valid;
	logic r_ready;
	axi_req_t aw;
	logic aw_valid;
	logic aw_ready;
	w_beat_t w;
	logic w_valid;
	logic w_ready;
	b_resp_t b;
	logic b_valid;
	logic b_ready;
	int value_errors;
	int protocol_errors;
	int pending;

	integer seed = 32'h7e8a;
	axi_req_t wr_list[$];
	axi_req_t rd_list[$];
	w_beat_t beat_list[$];
	int total_beats;
	int next_id;
	int limit;
	int cycles;

	axi_mem_top dut (.*);
	axi_checker scoreboard (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic add_burst(bit is_write, logic [31:0] addr, int len, burst_t kind,
		bit all_bytes);
		axi_req_t req;
		w_beat_t beat;
		req.addr = addr;
		req.id = id_w'(next_id);
		req.len = len_w'(len);
		req.size = 3'd2; // full word beats
		req.burst = kind;
		next_id++;
		total_beats += len + 1;
		if (is_write) begin
			wr_list.push_back(req);
			for (int j = 0; j <= len; j++) begin
				beat.data = $random(seed);
				beat.strb = all_bytes ? '1 : strb_w'($random(seed));
				beat.last = (j == len);
				beat_list.push_back(beat);
			end
		end else begin
			rd_list.push_back(req);
		end
	endtask

	// first 512 bytes of RAM so reads overlap earlier writes
	task automatic random_burst(bit is_write);
		logic [31:0] addr;
		int len;
		burst_t kind;
		addr = ram_base + {23'd0, 7'($random(seed)), 2'b00};
		len = $random(seed) & 7;
		kind = ($random(seed) & 1) ? burst_incr : burst_fixed;
		add_burst(is_write, addr, len, kind, 1'b0);
	endtask

	task automatic send_aw();
		foreach (wr_list[i]) begin
			aw = wr_list[i];
			aw_valid = 1'b1;
			while (!aw_ready)
				@(negedge clock);
			@(negedge clock); // taken on the edge in between
		end
		aw_valid = 1'b0;
	endtask

	task automatic send_w();
		foreach (beat_list[i]) begin
			w = beat_list[i];
			w_valid = 1'b1;
			while (!w_ready)
				@(negedge clock);
			@(negedge clock);
		end
		w_valid = 1'b0;
	endtask

	task automatic send_ar();
		foreach (rd_list[i]) begin
			ar = rd_list[i];
			ar_valid = 1'b1;
			while (!ar_ready)
				@(negedge clock);
			@(negedge clock);
		end
		ar_valid = 1'b0;
	endtask

	task automatic drain();
		while (pending != 0)
			@(negedge clock);
	endtask

	initial begin
		reset = 1'b1;
		ar = '0;
		ar_valid = 1'b0;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		r_ready = 1'b0;
		b_ready = 1'b0;
		for (int i = 0; i < 24; i++)
			random_burst(1);
		add_burst(1, ram_base, 1, burst_incr, 1'b1); // first two words fully known
		// just past RAM, would alias onto the two words above
		add_burst(1, ram_base + ram_bytes, 1, burst_incr, 1'b1);
		for (int i = 0; i < 24; i++)
			random_burst(0);
		add_burst(0, ram_base, 1, burst_incr, 1'b0); // untouched by the write past RAM
		add_burst(0, 32'h4000_0000, 2, burst_incr, 1'b0); // unmapped
		add_burst(0, ram_base + ram_bytes, 1, burst_incr, 1'b0);
		add_burst(0, timer_base, 3, burst_fixed, 1'b0); // low word four times
		add_burst(0, timer_base, 1, burst_incr, 1'b0); // low then high
		limit = 20 * total_beats + 200;
		repeat (4) @(negedge clock);
		reset = 1'b0;
		fork
			send_aw();
			send_w();
		join
		drain();
		send_ar();
		drain();
		$display("checks done: %0d value errors, %0d protocol errors",
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// random stretches of r_ready and b_ready back-pressure
	initial begin
		int hold;
		hold = 0;
		forever begin
			@(negedge clock);
			if (hold == 0) begin
				hold = 1 + ($random(seed) & 7);
				r_ready = ($random(seed) & 3) != 0;
				b_ready = ($random(seed) & 3) != 0;
			end
			hold--;
		end
	end

	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		$display(
			"timeout at cycle %0d, %0d open requests, %0d value errors, %0d protocol errors",
			cycles, pending, value_errors, protocol_errors);
		$display("Verification failed");
		$finish;
	end

endmodule

/* sources.f */
logic/axi_mem_pkg.sv
logic/req_queue.sv
logic/mem_map.sv
logic/read_engine.sv
logic/write_engine.sv
logic/axi_mem_top.sv
testbench/axi_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and pass only on the testbench's pass line
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_top -f sources.f -o tb_sim
out=$(./obj_dir/tb_sim || true)
echo "$out"
echo "$out" | grep -q "Verification passed"
